/* rtl/rv_pkg.sv */
////////////////////
// RV32I core package
// Opcodes, control encodings and the payloads of the stage registers
////////////////////
`default_nettype none

package rv_pkg;

   localparam int xlen = 32;
   localparam logic [xlen-1:0] reset_pc = 32'h0001_0000;
   localparam logic [31:0] nop_inst = 32'h0000_0013;   // addi x0,x0,0

   // Major opcodes of the supported subset
   localparam logic [6:0] op_r      = 7'b0110011;
   localparam logic [6:0] op_i      = 7'b0010011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_jal    = 7'b1101111;

   // Operand forward selects
   localparam logic [1:0] fwd_none = 2'b00;
   localparam logic [1:0] fwd_wb   = 2'b01;
   localparam logic [1:0] fwd_mem  = 2'b10;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
   } alu_op_e;

   typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;

   typedef enum logic [1:0] {res_alu, res_load, res_pc4} result_sel_e;

   // Log2 of the access width in bytes
   typedef enum logic [1:0] {size_byte = 2'b00, size_word = 2'b10} byte_size_e;

   typedef struct packed {
      logic        reg_write;
      logic        mem_write;
      logic        mem_req;
      logic        alu_src_imm;
      logic        branch;
      logic        branch_ne;
      logic        jump;
      logic        load_unsigned;
      alu_op_e     alu_op;
      result_sel_e result_sel;
      byte_size_e  byte_size;
   } ctrl_t;

   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [xlen-1:0] pc4;
      logic [31:0]     inst;
   } if_id_t;

   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [xlen-1:0] pc4;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [4:0]      rd;
      logic [xlen-1:0] rs1_data;
      logic [xlen-1:0] rs2_data;
      logic [xlen-1:0] imm;
      ctrl_t           ctrl;
   } id_ex_t;

   typedef struct packed {
      logic [xlen-1:0] pc4;
      logic [xlen-1:0] alu_out;
      logic [xlen-1:0] store_data;
      logic [4:0]      rd;
      ctrl_t           ctrl;
   } ex_mem_t;

   typedef struct packed {
      logic [xlen-1:0] pc4;
      logic [xlen-1:0] alu_out;
      logic [xlen-1:0] load_data;
      logic [4:0]      rd;
      logic            reg_write;
      result_sel_e     result_sel;
   } mem_wb_t;

endpackage

`default_nettype wire

/* rtl/rv_decoder.sv */
////////////////////
// Instruction decoder
// Control bits and sign-extended immediate for the RV32I subset
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
   input  wire [31:0]   inst,
   output rv_pkg::ctrl_t ctrl,
   output logic [31:0]  imm
);
   import rv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       r_ok;     // funct7 legal for add/sub and logic ops
   logic       alu_ok;   // funct3 is one of the supported ALU ops
   alu_op_e    alu_fn;
   imm_sel_e   imm_sel;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   assign r_ok   = !inst[31] && inst[29:25] == 5'd0 && (!inst[30] || funct3 == 3'b000);

   // ALU function shared by register and immediate forms
   always_comb begin
      alu_ok = 1'b1;
      case (funct3)
         3'b000:  alu_fn = (opcode == op_r && inst[30]) ? alu_sub : alu_add;
         3'b111:  alu_fn = alu_and;
         3'b110:  alu_fn = alu_or;
         3'b100:  alu_fn = alu_xor;
         3'b010:  alu_fn = alu_slt;
         default: begin
            alu_fn = alu_add;
            alu_ok = 1'b0;   // Shifts and sltu are not decoded
         end
      endcase
   end

   always_comb begin
      ctrl    = '0;
      imm_sel = imm_i;
      case (opcode)
         op_r: begin
            if (alu_ok && r_ok) begin
               ctrl.reg_write = 1'b1;
               ctrl.alu_op    = alu_fn;
            end
         end
         op_i: begin
            if (alu_ok) begin
               ctrl.reg_write   = 1'b1;
               ctrl.alu_src_imm = 1'b1;
               ctrl.alu_op      = alu_fn;
            end
         end
         op_load: begin
            if (funct3 == 3'b000 || funct3 == 3'b010) begin
               ctrl.reg_write   = 1'b1;
               ctrl.mem_req     = 1'b1;
               ctrl.alu_src_imm = 1'b1;
               ctrl.result_sel  = res_load;
               ctrl.byte_size   = funct3[1] ? size_word : size_byte;
            end
         end
         op_store: begin
            imm_sel = imm_s;
            if (funct3 == 3'b000 || funct3 == 3'b010) begin
               ctrl.mem_write   = 1'b1;
               ctrl.mem_req     = 1'b1;
               ctrl.alu_src_imm = 1'b1;
               ctrl.byte_size   = funct3[1] ? size_word : size_byte;
            end
         end
         op_branch: begin
            imm_sel = imm_b;
            if (funct3[2:1] == 2'b00) begin   // beq, bne
               ctrl.branch    = 1'b1;
               ctrl.branch_ne = funct3[0];
               ctrl.alu_op    = alu_sub;
            end
         end
         op_lui: begin
            imm_sel          = imm_u;
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = alu_pass_b;
         end
         op_jal: begin
            imm_sel         = imm_j;
            ctrl.reg_write  = 1'b1;
            ctrl.jump       = 1'b1;
            ctrl.result_sel = res_pc4;   // Link value
         end
         default: ;
      endcase
   end

   always_comb begin
      case (imm_sel)
         imm_s:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         imm_b:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
         imm_u:   imm = {inst[31:12], 12'd0};
         imm_j:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         default: imm = {{20{inst[31]}}, inst[31:20]};
      endcase
   end

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
////////////////////
// Register file, 32 x 32
// x0 reads zero, write data bypassed to reads
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
   input  wire        clk,
   input  wire        rst_n,
   input  wire [4:0]  rs1_addr,
   input  wire [4:0]  rs2_addr,
   output logic [31:0] rs1_data,
   output logic [31:0] rs2_data,
   input  wire        wr_en,
   input  wire [4:0]  wr_addr,
   input  wire [31:0] wr_data
);

   logic [31:0] regs [1:31];
   logic        wr_live;   // A real write, never to x0

   assign wr_live = wr_en && wr_addr != 5'd0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // WB result visible to ID in the same cycle
   assign rs1_data = (rs1_addr == 5'd0) ? '0 :
                     (wr_live && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
   assign rs2_data = (rs2_addr == 5'd0) ? '0 :
                     (wr_live && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

`default_nettype wire

/* rtl/rv_alu.sv */
////////////////////
// Integer ALU
// Add, sub, logic ops, signed compare and pass for lui
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
   input  wire [31:0]      a,
   input  wire [31:0]      b,
   input  wire rv_pkg::alu_op_e op,
   output logic [31:0]     result,
   output logic            zero
);
   import rv_pkg::*;

   always_comb begin
      case (op)
         alu_add:    result = a + b;
         alu_sub:    result = a - b;
         alu_and:    result = a & b;
         alu_or:     result = a | b;
         alu_xor:    result = a ^ b;
         alu_slt:    result = {31'd0, $signed(a) < $signed(b)};
         alu_pass_b: result = b;   // lui
         default:    result = '0;
      endcase
   end

   // Branch compare runs as a subtraction
   assign zero = (result == '0);

endmodule

`default_nettype wire

/* rtl/rv_hazard_unit.sv */
////////////////////
// Hazard unit
// Operand forwarding, load-use stall and redirect flush
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_hazard_unit (
   input  wire [4:0]  id_rs1,
   input  wire [4:0]  id_rs2,
   input  wire [4:0]  ex_rs1,
   input  wire [4:0]  ex_rs2,
   input  wire [4:0]  ex_rd,
   input  wire [4:0]  mem_rd,
   input  wire [4:0]  wb_rd,
   input  wire        ex_is_load,
   input  wire        mem_reg_write,
   input  wire        wb_reg_write,
   input  wire        ex_redirect,
   output logic [1:0] fwd_a,
   output logic [1:0] fwd_b,
   output logic       stall_if,
   output logic       stall_id,
   output logic       flush_if_id,
   output logic       flush_id_ex
);
   import rv_pkg::*;

   logic load_use;

   function automatic logic [1:0] fwd_select(input logic [4:0] rs);
      logic [1:0] sel;
      sel = fwd_none;
      if (wb_reg_write && wb_rd != 5'd0 && wb_rd == rs) sel = fwd_wb;
      if (mem_reg_write && mem_rd != 5'd0 && mem_rd == rs) sel = fwd_mem;   // Younger wins
      return sel;
   endfunction

   always_comb begin
      fwd_a = fwd_select(ex_rs1);
      fwd_b = fwd_select(ex_rs2);
   end

   // Load in EX feeding the instruction in ID
   assign load_use = ex_is_load && ex_rd != 5'd0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

   assign stall_if    = load_use;
   assign stall_id    = load_use;
   assign flush_if_id = ex_redirect;
   assign flush_id_ex = ex_redirect | load_use;   // Bubble into EX

endmodule

`default_nettype wire

/* rtl/rv_pipe_reg.sv */
////////////////////
// Pipeline stage register
// Stall holds, flush loads the reset payload
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_pipe_reg #(
   parameter type      payload_t   = logic,
   parameter payload_t reset_value = '0
) (
   input  wire           clk,
   input  wire           rst_n,
   input  wire           stall,
   input  wire           flush,
   input  wire payload_t d,
   output payload_t      q
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q <= reset_value;
      end else if (flush) begin
         q <= reset_value;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
////////////////////
// rv_core, five-stage RV32I pipeline
// Fetch, decode, execute, memory and write-back with hazard control
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_core (
   input  wire        clk,
   input  wire        rst_n,
   output logic [31:0] pc,
   input  wire [31:0] inst,
   output logic [31:0] data_addr,
   output logic [31:0] store_data,
   output logic       mem_req,
   output logic       write,
   output logic [1:0] byte_size,
   input  wire [31:0] load_data
);
   import rv_pkg::*;

   localparam if_id_t if_id_reset = '{pc: '0, pc4: '0, inst: nop_inst};

   if_id_t  if_id_d, if_id_q;
   id_ex_t  id_ex_d, id_ex_q;
   ex_mem_t ex_mem_d, ex_mem_q;
   mem_wb_t mem_wb_d, mem_wb_q;

   logic [31:0] pc4, branch_target;
   logic [31:0] rs1_data, rs2_data, id_imm;
   ctrl_t       id_ctrl;
   logic [31:0] operand_a, ex_store_data, alu_b, alu_out;
   logic [31:0] mem_fwd, wb_result;
   logic [7:0]  load_byte;
   logic [31:0] load_value;
   logic        alu_zero, ex_redirect;
   logic [1:0]  fwd_a, fwd_b;
   logic        stall_if, stall_id, flush_if_id, flush_id_ex;

   // Fetch
   assign pc4 = pc + 32'd4;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= reset_pc;
      end else if (!stall_if) begin
         pc <= ex_redirect ? branch_target : pc4;
      end
   end

   assign if_id_d = '{pc: pc, pc4: pc4, inst: inst};

   rv_pipe_reg #(.payload_t(if_id_t), .reset_value(if_id_reset)) i_if_id (
      .clk(clk), .rst_n(rst_n), .stall(stall_id), .flush(flush_if_id),
      .d(if_id_d), .q(if_id_q)
   );

   // Decode
   rv_decoder i_decoder (.inst(if_id_q.inst), .ctrl(id_ctrl), .imm(id_imm));

   rv_regfile i_regfile (
      .clk(clk), .rst_n(rst_n),
      .rs1_addr(if_id_q.inst[19:15]), .rs2_addr(if_id_q.inst[24:20]),
      .rs1_data(rs1_data), .rs2_data(rs2_data),
      .wr_en(mem_wb_q.reg_write), .wr_addr(mem_wb_q.rd), .wr_data(wb_result)
   );

   assign id_ex_d = '{pc: if_id_q.pc, pc4: if_id_q.pc4,
                      rs1: if_id_q.inst[19:15], rs2: if_id_q.inst[24:20],
                      rd: if_id_q.inst[11:7], rs1_data: rs1_data, rs2_data: rs2_data,
                      imm: id_imm, ctrl: id_ctrl};

   rv_pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
      .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(flush_id_ex),
      .d(id_ex_d), .q(id_ex_q)
   );

   // Execute
   always_comb begin
      case (fwd_a)
         fwd_mem: operand_a = mem_fwd;
         fwd_wb:  operand_a = wb_result;
         default: operand_a = id_ex_q.rs1_data;
      endcase
      case (fwd_b)
         fwd_mem: ex_store_data = mem_fwd;
         fwd_wb:  ex_store_data = wb_result;
         default: ex_store_data = id_ex_q.rs2_data;
      endcase
   end

   assign alu_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : ex_store_data;

   rv_alu i_alu (.a(operand_a), .b(alu_b), .op(id_ex_q.ctrl.alu_op),
                 .result(alu_out), .zero(alu_zero));

   assign branch_target = id_ex_q.pc + id_ex_q.imm;   // Branch and jal
   assign ex_redirect   = (id_ex_q.ctrl.branch && (alu_zero ^ id_ex_q.ctrl.branch_ne))
                          || id_ex_q.ctrl.jump;

   assign ex_mem_d = '{pc4: id_ex_q.pc4, alu_out: alu_out, store_data: ex_store_data,
                       rd: id_ex_q.rd, ctrl: id_ex_q.ctrl};

   rv_pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
      .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
      .d(ex_mem_d), .q(ex_mem_q)
   );

   // Memory
   assign data_addr  = ex_mem_q.alu_out;
   assign store_data = ex_mem_q.store_data;
   assign mem_req    = ex_mem_q.ctrl.mem_req;
   assign write      = ex_mem_q.ctrl.mem_write;
   assign byte_size  = ex_mem_q.ctrl.byte_size;

   // Byte lane of the returned word
   assign load_byte  = load_data[{data_addr[1:0], 3'b000} +: 8];
   assign load_value = (ex_mem_q.ctrl.byte_size == size_byte) ?
                       {{24{load_byte[7] & ~ex_mem_q.ctrl.load_unsigned}}, load_byte} :
                       load_data;

   // jal in MEM forwards its link value
   assign mem_fwd = (ex_mem_q.ctrl.result_sel == res_pc4) ? ex_mem_q.pc4 : ex_mem_q.alu_out;

   assign mem_wb_d = '{pc4: ex_mem_q.pc4, alu_out: ex_mem_q.alu_out, load_data: load_value,
                       rd: ex_mem_q.rd, reg_write: ex_mem_q.ctrl.reg_write,
                       result_sel: ex_mem_q.ctrl.result_sel};

   rv_pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
      .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
      .d(mem_wb_d), .q(mem_wb_q)
   );

   // Write-back
   always_comb begin
      case (mem_wb_q.result_sel)
         res_load: wb_result = mem_wb_q.load_data;
         res_pc4:  wb_result = mem_wb_q.pc4;
         default:  wb_result = mem_wb_q.alu_out;
      endcase
   end

   rv_hazard_unit i_hazard (
      .id_rs1(if_id_q.inst[19:15]), .id_rs2(if_id_q.inst[24:20]),
      .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2), .ex_rd(id_ex_q.rd),
      .mem_rd(ex_mem_q.rd), .wb_rd(mem_wb_q.rd),
      .ex_is_load(id_ex_q.ctrl.mem_req && !id_ex_q.ctrl.mem_write),
      .mem_reg_write(ex_mem_q.ctrl.reg_write), .wb_reg_write(mem_wb_q.reg_write),
      .ex_redirect(ex_redirect),
      .fwd_a(fwd_a), .fwd_b(fwd_b),
      .stall_if(stall_if), .stall_id(stall_id),
      .flush_if_id(flush_if_id), .flush_id_ex(flush_id_ex)
   );

endmodule

`default_nettype wire

/* sim/rv_core_properties.sv */
////////////////////
// rv_core assertions
// Memory-port rules and load-use stall length
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rv_core_properties (
   input wire clk,
   input wire rst_n,
   input wire mem_req,
   input wire write,
   input wire stall_if
);

   int failures = 0;   // Count of failed assertions

   a_write_with_req: assert property (@(posedge clk) disable iff (!rst_n) write |-> mem_req)
      else begin
         $error("write high without mem_req");
         failures++;
      end

   // Control bits cleared by reset
   a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !mem_req)
      else begin
         $error("mem_req high in the first cycle after reset");
         failures++;
      end

   a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                                       $rose(stall_if) |=> !stall_if)
      else begin
         $error("load-use stall longer than one cycle");
         failures++;
      end

endmodule

bind rv_core rv_core_properties i_props (
   .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .write(write), .stall_if(stall_if)
);

`default_nettype wire

/* sim/tb_rv_core.sv */
////////////////////
// rv_core testbench
// Runs a table of small programs against ROM and RAM models and checks the stores
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
   import rv_pkg::*;

   localparam int n_tests = 5;

   logic        clk;
   logic        rst_n = 1'b0;
   logic [31:0] pc, inst, data_addr, store_data, load_data;
   logic        mem_req, write;
   logic [1:0]  byte_size;

   logic [31:0] rom [0:255];
   logic [7:0]  ram [0:1023];
   logic [7:0]  ram_ref [0:1023];   // Background contents, restored at every reset

   string       t_name [n_tests];
   logic [31:0] t_prog [n_tests][16];
   int          t_nstore [n_tests];
   logic [31:0] t_addr [n_tests][4];
   logic [31:0] t_data [n_tests][4];
   logic [1:0]  t_size [n_tests][4];
   int          row, prog_len;

   logic [31:0] cap_addr [8];
   logic [31:0] cap_data [8];
   logic [1:0]  cap_size [8];
   int          n_seen, n_access;
   logic        first_write;
   int          errors, test_errs, failed;

   rv_core i_dut (.clk(clk), .rst_n(rst_n), .pc(pc), .inst(inst), .data_addr(data_addr),
                  .store_data(store_data), .mem_req(mem_req), .write(write),
                  .byte_size(byte_size), .load_data(load_data));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Both memories answer in the same cycle
   assign inst      = (pc[31:10] == reset_pc[31:10]) ? rom[pc[9:2]] : nop_inst;
   assign load_data = (mem_req && !write) ?
                      {ram[{data_addr[9:2], 2'd3}], ram[{data_addr[9:2], 2'd2}],
                       ram[{data_addr[9:2], 2'd1}], ram[{data_addr[9:2], 2'd0}]} : '0;

   always @(posedge clk) begin
      if (!rst_n) begin
         n_seen      <= 0;
         n_access    <= 0;
         first_write <= 1'b0;
         for (int i = 0; i < 1024; i++) ram[i] <= ram_ref[i];
      end else if (mem_req) begin
         n_access <= n_access + 1;
         if (n_access == 0) first_write <= write;
         if (write) begin
            if (n_seen < 8) begin
               cap_addr[n_seen] <= data_addr;
               cap_data[n_seen] <= store_data;
               cap_size[n_seen] <= byte_size;
            end
            n_seen <= n_seen + 1;
            if (byte_size == size_byte) begin
               ram[data_addr[9:0]] <= store_data[7:0];
            end else begin
               for (int b = 0; b < 4; b++) begin
                  ram[{data_addr[9:2], 2'(b)}] <= store_data[8*b +: 8];
               end
            end
         end
      end
   end

   // RV32I encodings
   function automatic logic [31:0] alu_reg(input logic [2:0] f3, input logic [6:0] f7,
                                           input logic [4:0] rd, rs1, rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] alu_imm(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                           input int imm);
      return {imm[11:0], rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] load_inst(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                             input int imm);
      return {imm[11:0], rs1, f3, rd, 7'b0000011};
   endfunction

   function automatic logic [31:0] store_inst(input logic [2:0] f3, input logic [4:0] rs2, rs1,
                                              input int imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                               input int imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] jal_inst(input logic [4:0] rd, input int imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic begin_row(input string name);
      row = row + 1;
      prog_len = 0;
      t_name[row] = name;
      t_nstore[row] = 0;
      for (int i = 0; i < 16; i++) t_prog[row][i] = nop_inst;
   endtask

   task automatic add_inst(input logic [31:0] word);
      t_prog[row][prog_len] = word;
      prog_len++;
   endtask

   task automatic expect_store(input logic [31:0] addr, data, input logic [1:0] size);
      t_addr[row][t_nstore[row]] = addr;
      t_data[row][t_nstore[row]] = data;
      t_size[row][t_nstore[row]] = size;
      t_nstore[row]++;
   endtask

   task automatic build_table;
      logic [31:0] r [0:15];
      begin_row("alu_forwarding");
      add_inst(alu_imm(3'b000, 1, 0, 'h123));          // addi x1,x0,0x123
      add_inst(alu_imm(3'b000, 2, 0, -69));
      add_inst(alu_reg(3'b000, 7'h00, 3, 1, 2));       // add, both operands forwarded
      add_inst(alu_reg(3'b000, 7'h20, 4, 1, 3));       // sub
      add_inst(alu_reg(3'b111, 7'h00, 5, 3, 2));       // and
      add_inst(alu_reg(3'b110, 7'h00, 6, 5, 4));       // or
      add_inst(alu_reg(3'b100, 7'h00, 7, 6, 1));       // xor
      add_inst(store_inst(3'b010, 7, 0, 'h100));       // sw x7
      add_inst(alu_reg(3'b010, 7'h00, 8, 2, 1));       // slt
      add_inst(alu_imm(3'b100, 9, 7, 'h5a5));          // xori
      add_inst(alu_imm(3'b111, 10, 9, 'h3f0));         // andi
      add_inst(alu_imm(3'b110, 11, 10, -2048));        // ori
      add_inst(alu_imm(3'b010, 12, 11, 0));            // slti
      add_inst(store_inst(3'b010, 11, 0, 'h104));
      add_inst(alu_reg(3'b000, 7'h00, 13, 8, 12));
      add_inst(store_inst(3'b010, 13, 0, 'h108));
      r[1] = 32'h123;
      r[2] = -69;
      r[3] = r[1] + r[2];
      r[4] = r[1] - r[3];
      r[5] = r[3] & r[2];
      r[6] = r[5] | r[4];
      r[7] = r[6] ^ r[1];
      r[8] = ($signed(r[2]) < $signed(r[1])) ? 32'd1 : 32'd0;
      r[9] = r[7] ^ 32'h5a5;
      r[10] = r[9] & 32'h3f0;
      r[11] = r[10] | 32'hffff_f800;
      r[12] = ($signed(r[11]) < 0) ? 32'd1 : 32'd0;
      r[13] = r[8] + r[12];
      expect_store('h100, r[7], size_word);
      expect_store('h104, r[11], size_word);
      expect_store('h108, r[13], size_word);

      begin_row("load_use_stall");
      ram_ref['h213] = ram_ref['h213] | 8'h80;         // Negative background byte for lb
      add_inst(alu_imm(3'b000, 1, 0, 'h321));
      add_inst(store_inst(3'b010, 1, 0, 'h200));
      add_inst(load_inst(3'b010, 2, 0, 'h200));        // lw x2
      add_inst(alu_reg(3'b000, 7'h00, 3, 2, 1));       // Uses x2 right away
      add_inst(store_inst(3'b010, 3, 0, 'h204));
      add_inst(load_inst(3'b000, 5, 0, 'h213));        // lb x5
      add_inst(store_inst(3'b010, 5, 0, 'h208));       // Load-use through rs2
      expect_store('h200, 'h321, size_word);
      expect_store('h204, 'h321 + 'h321, size_word);
      expect_store('h208, {{24{ram_ref['h213][7]}}, ram_ref['h213]}, size_word);

      begin_row("branch_flush");
      add_inst(alu_imm(3'b000, 1, 0, 7));
      add_inst(alu_imm(3'b000, 2, 0, 7));
      add_inst(branch_inst(3'b000, 1, 2, 12));         // beq taken
      add_inst(store_inst(3'b010, 1, 0, 'h300));       // Wrong path
      add_inst(store_inst(3'b010, 2, 0, 'h304));       // Wrong path
      add_inst(alu_imm(3'b000, 3, 0, 'h55));
      add_inst(store_inst(3'b010, 3, 0, 'h308));
      add_inst(branch_inst(3'b001, 1, 2, 8));          // bne not taken
      add_inst(alu_imm(3'b000, 4, 3, 1));
      add_inst(store_inst(3'b010, 4, 0, 'h30c));
      add_inst(branch_inst(3'b001, 1, 3, 8));          // bne taken
      add_inst(store_inst(3'b010, 1, 0, 'h314));       // Wrong path
      add_inst(store_inst(3'b010, 4, 0, 'h310));
      expect_store('h308, 'h55, size_word);
      expect_store('h30c, 'h56, size_word);
      expect_store('h310, 'h56, size_word);

      begin_row("jal_link");
      add_inst(alu_imm(3'b000, 1, 0, 3));
      add_inst(jal_inst(5, 8));                         // Skips the next store
      add_inst(store_inst(3'b010, 1, 0, 'h400));
      add_inst(store_inst(3'b010, 5, 0, 'h404));
      add_inst(jal_inst(0, 8));
      add_inst(store_inst(3'b010, 1, 0, 'h408));
      add_inst(store_inst(3'b010, 1, 0, 'h40c));
      add_inst(jal_inst(6, 4));                         // Jump to the next word
      add_inst(alu_reg(3'b000, 7'h00, 7, 6, 0));
      add_inst(store_inst(3'b010, 7, 0, 'h410));
      expect_store('h404, reset_pc + 32'd8, size_word);
      expect_store('h40c, 32'd3, size_word);
      expect_store('h410, reset_pc + 32'h20, size_word);

      begin_row("lui_sb_x0");
      add_inst(lui_inst(1, 20'h12345));
      add_inst(alu_imm(3'b000, 1, 1, 'h678));
      add_inst(store_inst(3'b010, 1, 0, 'h500));
      add_inst(store_inst(3'b000, 1, 0, 'h505));       // sb
      add_inst(alu_imm(3'b000, 0, 0, 'h77));           // Write to x0
      add_inst(store_inst(3'b010, 0, 0, 'h508));
      add_inst(lui_inst(3, 20'hfffff));
      add_inst(alu_imm(3'b000, 3, 3, -1));
      add_inst(store_inst(3'b010, 3, 0, 'h50c));
      expect_store('h500, 32'h1234_5678, size_word);
      expect_store('h505, 32'h78, size_byte);
      expect_store('h508, 32'd0, size_word);
      expect_store('h50c, 32'hffff_f000 + 32'hffff_ffff, size_word);
   endtask

   task automatic run_test(input int t);
      int  cyc;
      logic data_ok;
      test_errs = 0;
      @(posedge clk);
      rst_n <= 1'b0;
      for (int i = 0; i < 16; i++) rom[i] <= t_prog[t][i];
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      assert (pc == reset_pc && !mem_req) else begin
         $display("MISMATCH t=%0t %s: pc %h mem_req %b after reset",
                  $time, t_name[t], pc, mem_req);
         test_errs++;
      end
      cyc = 0;
      while (n_seen < t_nstore[t] && cyc < 200) begin
         @(posedge clk);
         cyc++;
      end
      if (n_seen < t_nstore[t]) begin
         $display("%s: timed out after 200 cycles with %0d of %0d stores seen",
                  t_name[t], n_seen, t_nstore[t]);
         test_errs++;
      end else begin
         // Run until the last ROM word has left MEM
         cyc = 0;
         while (pc < reset_pc + 32'h50 && cyc < 200) begin
            @(posedge clk);
            cyc++;
         end
         if (pc < reset_pc + 32'h50) begin
            $display("%s: program did not run past its last word within 200 cycles",
                     t_name[t]);
            test_errs++;
         end
      end
      assert (n_seen == t_nstore[t]) else begin
         $display("MISMATCH t=%0t %s: %0d stores seen, %0d expected",
                  $time, t_name[t], n_seen, t_nstore[t]);
         test_errs++;
      end
      assert (first_write) else begin
         $display("MISMATCH t=%0t %s: first data access was not a store", $time, t_name[t]);
         test_errs++;
      end
      for (int i = 0; i < t_nstore[t] && i < n_seen && i < 8; i++) begin
         data_ok = (t_size[t][i] == size_byte) ? cap_data[i][7:0] == t_data[t][i][7:0]
                                               : cap_data[i] == t_data[t][i];
         assert (cap_addr[i] == t_addr[t][i] && cap_size[i] == t_size[t][i] && data_ok) else begin
            $display("MISMATCH t=%0t %s store %0d: got %h %h %0d, expected %h %h %0d",
                     $time, t_name[t], i, cap_addr[i], cap_data[i], cap_size[i],
                     t_addr[t][i], t_data[t][i], t_size[t][i]);
            test_errs++;
         end
      end
      $display("test %0d %s: %s", t, t_name[t], (test_errs == 0) ? "passed" : "failed");
      errors += test_errs;
      if (test_errs != 0) failed++;
   endtask

   initial begin
      errors = 0;
      failed = 0;
      row = -1;
      void'($urandom(32'ha25b_b11a));
      for (int i = 0; i < 1024; i++) ram_ref[i] = 8'($urandom);
      for (int i = 0; i < 256; i++) rom[i] = nop_inst;
      build_table();
      for (int t = 0; t < n_tests; t++) run_test(t);
      assert (i_dut.i_props.failures == 0) else begin
         $display("bound assertions failed %0d times", i_dut.i_props.failures);
         errors++;
      end
      $display("%0d tests run, %0d failed, %0d errors", n_tests, failed, errors);
      if (failed == 0 && errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rv_core.f */
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_hazard_unit.sv
rtl/rv_pipe_reg.sv
rtl/rv_core.sv
sim/rv_core_properties.sv
sim/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rtl/rv_pkg.sv
  - rtl/rv_decoder.sv
  - rtl/rv_regfile.sv
  - rtl/rv_alu.sv
  - rtl/rv_hazard_unit.sv
  - rtl/rv_pipe_reg.sv
  - rtl/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_properties.sv
      - sim/tb_rv_core.sv
